// ==== files.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_store.sv
rtl/dcache_align.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int LINE_W     = `DC_WORDS_PER_LINE * `DC_DATA_WIDTH;
    localparam int MAX_ROWS   = 32;
    localparam int WORST_MISS = 10; // Lookup, writeback, refill, respond
    localparam int SLOW_DELAY = 20;
    localparam int MARGIN     = 20;

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    logic              req_write;
    logic [31:0]       req_addr;
    logic [2:0]        req_size;
    logic [31:0]       req_wdata;
    logic              req_ready;
    logic              resp_valid;
    logic [31:0]       resp_rdata;
    logic              mem_req_valid;
    mem_cmd_t          mem_req_cmd;
    logic [31:0]       mem_req_addr;
    logic [LINE_W-1:0] mem_req_line;
    logic              mem_credit;
    logic              mem_resp_valid;
    logic [LINE_W-1:0] mem_resp_line;
    logic [7:0]        credit_delay;

    string       row_name   [MAX_ROWS];
    logic        row_write  [MAX_ROWS];
    logic [31:0] row_addr   [MAX_ROWS];
    logic [2:0]  row_size   [MAX_ROWS];
    logic [31:0] row_data   [MAX_ROWS];
    logic [31:0] row_exp    [MAX_ROWS];
    logic        row_hit    [MAX_ROWS]; // Must answer 2 cycles after acceptance
    logic        row_wb     [MAX_ROWS]; // Expects one MEM_WRITE
    logic [31:0] row_victim [MAX_ROWS]; // Line address of the evicted line
    logic [7:0]  row_delay  [MAX_ROWS];
    logic [7:0]  ref_mem    [1024];
    int          n_rows = 0;
    int          cur_row = 0;
    int          seed = 32'hf672_d156;
    int          mismatches = 0;
    int          failures = 0;
    int          wb_seen = 0;
    int          cycles = 0;
    int          timeout_limit;

    always #2 clk = ~clk;

    dcache_top i_dcache_top (.*);

    dcache_mem_model i_mem_model (.*);

    bind dcache_ctrl dcache_checker i_dcache_checker (
        .clk(clk), .reset(reset), .req_ready(req_ready), .resp_valid(resp_valid),
        .mem_req_valid(mem_req_valid), .mem_credit(mem_credit)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[31:16]};
    endfunction

    task automatic init_ref();
        logic [31:0] w;
        for (int a = 0; a < 1024; a += 4) begin
            w = fill_word(a);
            for (int b = 0; b < 4; b++) begin
                ref_mem[a + b] = w[b*8 +: 8];
            end
        end
    endtask

    // Zero-extended, unsupported sizes read as zero
    function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] size);
        logic [9:0] a;
        a = addr[9:0];
        case (size)
            3'b000:  return {24'h0, ref_mem[a]};
            3'b001:  return {16'h0, ref_mem[a + 1], ref_mem[a]};
            3'b010:  return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
            default: return 32'h0;
        endcase
    endfunction

    task automatic ref_store(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        int n;
        n = (size == 3'b000) ? 1 : (size == 3'b001) ? 2 : (size == 3'b010) ? 4 : 0;
        for (int b = 0; b < n; b++) begin
            ref_mem[addr[9:0] + b] = data[b*8 +: 8];
        end
    endtask

    task automatic add_row(input string name, input logic write, input logic [31:0] addr,
                           input logic [2:0] size, input logic hit, input logic wb,
                           input logic [31:0] victim, input logic [7:0] delay);
        row_name[n_rows]   = name;
        row_write[n_rows]  = write;
        row_addr[n_rows]   = addr;
        row_size[n_rows]   = size;
        row_data[n_rows]   = write ? $random(seed) : 32'h0;
        row_exp[n_rows]    = 32'h0;
        row_hit[n_rows]    = hit;
        row_wb[n_rows]     = wb;
        row_victim[n_rows] = victim;
        row_delay[n_rows]  = delay;
        n_rows++;
    endtask

    task automatic apply_row(input int i);
        int latency;
        int wb_before;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        cur_row = i;
        req_valid    <= 1'b1;
        req_write    <= row_write[i];
        req_addr     <= row_addr[i];
        req_size     <= row_size[i];
        req_wdata    <= row_data[i];
        credit_delay <= row_delay[i];
        @(posedge clk); // Accepted here
        req_valid <= 1'b0;
        if (row_write[i]) begin
            ref_store(row_addr[i], row_size[i], row_data[i]);
        end
        wb_before = wb_seen;
        latency   = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!resp_valid);
        if (!row_write[i]) begin
            assert (resp_rdata === row_exp[i]) else begin
                mismatches++;
                $display("Mismatch %s: expected %h, actual %h",
                         row_name[i], row_exp[i], resp_rdata);
            end
        end
        if (row_hit[i]) begin
            assert (latency == 2) else begin
                mismatches++;
                $display("Mismatch %s latency: expected 2, actual %0d", row_name[i], latency);
            end
        end
        assert (wb_seen - wb_before == int'(row_wb[i])) else begin
            mismatches++;
            $display("Mismatch %s writebacks: expected %0d, actual %0d",
                     row_name[i], row_wb[i], wb_seen - wb_before);
        end
    endtask

    // Victim data has to match the reference copy of its line
    always @(posedge clk) begin
        logic [LINE_W-1:0] exp_line;
        logic [31:0]       exp_addr;
        if (!reset && mem_req_valid && mem_req_cmd == MEM_WRITE) begin
            wb_seen++;
            exp_addr = row_victim[cur_row];
            for (int b = 0; b < LINE_W/8; b++) begin
                exp_line[b*8 +: 8] = ref_mem[exp_addr[9:0] + b];
            end
            assert (mem_req_addr === exp_addr) else begin
                mismatches++;
                $display("Mismatch %s writeback address: expected %h, actual %h",
                         row_name[cur_row], exp_addr, mem_req_addr);
            end
            assert (mem_req_line === exp_line) else begin
                mismatches++;
                $display("Mismatch %s writeback at %h: expected %h, actual %h",
                         row_name[cur_row], exp_addr, exp_line, mem_req_line);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: no response within %0d cycles", timeout_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_size     = '0;
        req_wdata    = '0;
        credit_delay = 8'd3;
        //      name             wr addr     size    hit wb victim   delay
        add_row("ld_miss",        0, 32'h000, 3'b010, 0, 0, 32'h000, 8'd3);
        add_row("ld_hit",         0, 32'h004, 3'b010, 1, 0, 32'h000, 8'd3);
        add_row("ld_hit_half",    0, 32'h00e, 3'b001, 1, 0, 32'h000, 8'd3);
        add_row("sb_off0",        1, 32'h010, 3'b000, 0, 0, 32'h000, 8'd3);
        add_row("sb_off1",        1, 32'h011, 3'b000, 1, 0, 32'h000, 8'd3);
        add_row("sb_off2",        1, 32'h012, 3'b000, 1, 0, 32'h000, 8'd3);
        add_row("sb_off3",        1, 32'h013, 3'b000, 1, 0, 32'h000, 8'd3);
        add_row("sh_off0",        1, 32'h014, 3'b001, 1, 0, 32'h000, 8'd3);
        add_row("sh_off2",        1, 32'h016, 3'b001, 1, 0, 32'h000, 8'd3);
        add_row("lw_bytes",       0, 32'h010, 3'b010, 1, 0, 32'h000, 8'd3);
        add_row("lw_halves",      0, 32'h014, 3'b010, 1, 0, 32'h000, 8'd3);
        add_row("clean_evict",    0, 32'h020, 3'b010, 0, 0, 32'h000, 8'd3);
        add_row("dirty_evict",    0, 32'h030, 3'b010, 0, 1, 32'h010, 8'd3);
        add_row("reload",         0, 32'h014, 3'b010, 0, 0, 32'h000, 8'd3);
        add_row("slow_sw_a",      1, 32'h040, 3'b010, 0, 0, 32'h000, 8'd20);
        add_row("slow_sw_b",      1, 32'h050, 3'b010, 0, 0, 32'h000, 8'd20);
        add_row("slow_ld_c",      0, 32'h060, 3'b010, 0, 1, 32'h040, 8'd20);
        add_row("slow_ld_d",      0, 32'h070, 3'b010, 0, 1, 32'h050, 8'd20);
        add_row("slow_ld_a",      0, 32'h040, 3'b010, 0, 0, 32'h000, 8'd20);
        add_row("slow_ld_b",      0, 32'h050, 3'b010, 0, 0, 32'h000, 8'd20);
        add_row("bad_size_ld",    0, 32'h044, 3'b011, 1, 0, 32'h000, 8'd3);
        add_row("bad_size_st",    1, 32'h044, 3'b011, 1, 0, 32'h000, 8'd3);
        add_row("after_bad_size", 0, 32'h044, 3'b010, 1, 0, 32'h000, 8'd3);
        init_ref();
        for (int i = 0; i < n_rows; i++) begin
            if (row_write[i]) begin
                ref_store(row_addr[i], row_size[i], row_data[i]);
            end else begin
                row_exp[i] = ref_load(row_addr[i], row_size[i]);
            end
        end
        init_ref(); // Replayed live for writeback checks
        timeout_limit = 16 + n_rows * (WORST_MISS + 2 * SLOW_DELAY + MARGIN);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        failures = i_dcache_top.i_dcache_ctrl.i_dcache_checker.fail_count;
        $display("Errors: %0d mismatches, %0d assertion failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/dcache_checker.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_checker (
    input logic clk,
    input logic reset,
    input logic req_ready,
    input logic resp_valid,
    input logic mem_req_valid,
    input logic mem_credit
);

    int credit_cnt;
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= `DC_MEM_CREDITS;
        end else begin
            credit_cnt <= credit_cnt + int'(mem_credit) - int'(mem_req_valid);
        end
    end

    credit_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> credit_cnt > 0)
        else begin
            fail_count++;
            $error("memory request issued with no credit left");
        end

    // Response only while the core side is closed
    resp_closed: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !req_ready)
        else begin
            fail_count++;
            $error("response pulse while the cache accepts requests");
        end

    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !mem_req_valid && !resp_valid && !req_ready)
        else begin
            fail_count++;
            $error("outputs not low in the first cycle after reset");
        end

endmodule

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

// Backing store covers addresses 0x000 to 0x3ff, one entry per line
module dcache_mem_model import dcache_pkg::*; #(
    parameter int READ_LAT = 2
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [7:0]                                   credit_delay,
    input  logic                                         mem_req_valid,
    input  mem_cmd_t                                     mem_req_cmd,
    input  logic [31:0]                                  mem_req_addr,
    input  logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] mem_req_line,
    output logic                                         mem_credit,
    output logic                                         mem_resp_valid,
    output logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] mem_resp_line
);

    logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] lines [64];
    logic [5:0] read_line;
    int         read_due;
    int         now;
    int         credit_due [$]; // Cycle at which each credit goes back

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[31:16]};
    endfunction

    initial begin
        for (int l = 0; l < 64; l++) begin
            for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
                lines[l][w*32 +: 32] = fill_word(32'(l * 16 + w * 4));
            end
        end
    end

    always @(posedge clk) begin
        int slot;
        slot = -1;
        if (reset) begin
            now      = 0;
            read_due = -1;
            credit_due.delete();
            mem_credit     <= 1'b0;
            mem_resp_valid <= 1'b0;
        end else begin
            now++;
            if (mem_req_valid) begin
                if (mem_req_cmd == MEM_WRITE) begin
                    lines[mem_req_addr[9:4]] = mem_req_line;
                end else begin
                    read_due  = now + READ_LAT - 1;
                    read_line = mem_req_addr[9:4];
                end
                // Never ahead of the read data
                credit_due.push_back(now + ((credit_delay > READ_LAT) ? credit_delay : READ_LAT));
            end
            foreach (credit_due[k]) begin
                if (slot < 0 && credit_due[k] <= now) begin
                    slot = k;
                end
            end
            if (slot >= 0) begin
                credit_due.delete(slot);
            end
            mem_credit     <= (slot >= 0); // One credit per cycle at most
            mem_resp_valid <= (now == read_due);
            mem_resp_line  <= lines[read_line];
        end
    end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         req_valid,
    input  logic                                         req_write,
    input  logic [31:0]                                  req_addr,
    input  logic [2:0]                                   req_size,
    input  logic [`DC_DATA_WIDTH-1:0]                    req_wdata,
    output logic                                         req_ready,
    output logic                                         resp_valid,
    output logic [`DC_DATA_WIDTH-1:0]                    resp_rdata,
    output logic                                         mem_req_valid,
    output mem_cmd_t                                     mem_req_cmd,
    output logic [31:0]                                  mem_req_addr,
    output logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] mem_req_line,
    input  logic                                         mem_credit,
    input  logic                                         mem_resp_valid,
    input  logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] mem_resp_line
);

    access_size_t                    size_q;
    logic [`DC_DATA_WIDTH-1:0]       wdata_q;
    logic                            hit;
    logic                            line_dirty;
    logic [`DC_TAG_WIDTH-1:0]        line_tag;
    logic                            word_we;
    logic                            line_we;
    logic [31:0]                     lookup_addr;
    logic [`DC_DATA_WIDTH-1:0]       word_rdata;
    logic [`DC_DATA_WIDTH-1:0]       merged_word;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            size_q  <= access_size_t'(req_size); // Codes above 010 stay unsupported
            wdata_q <= req_wdata;
        end
    end

    dcache_ctrl i_dcache_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .hit            (hit),
        .line_dirty     (line_dirty),
        .line_tag       (line_tag),
        .word_we        (word_we),
        .line_we        (line_we),
        .lookup_addr    (lookup_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_cmd    (mem_req_cmd),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid)
    );

    dcache_store i_dcache_store (
        .clk        (clk),
        .reset      (reset),
        .index      (lookup_addr[4]),
        .tag        (lookup_addr[31:5]),
        .offset     (lookup_addr[3:2]),
        .word_we    (word_we),
        .word_wdata (merged_word),
        .line_we    (line_we),
        .line_wdata (mem_resp_line),
        .hit        (hit),
        .line_dirty (line_dirty),
        .line_tag   (line_tag),
        .line_rdata (mem_req_line), // Writeback payload
        .word_rdata (word_rdata)
    );

    dcache_align i_dcache_align (
        .size        (size_q),
        .offset_byte (lookup_addr[1:0]),
        .old_word    (word_rdata),
        .store_data  (wdata_q),
        .load_data   (resp_rdata),
        .merged_word (merged_word)
    );

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  logic [31:0]              req_addr,
    output logic                     req_ready,
    output logic                     resp_valid,
    input  logic                     hit,
    input  logic                     line_dirty,
    input  logic [`DC_TAG_WIDTH-1:0] line_tag,
    output logic                     word_we,
    output logic                     line_we,
    output logic [31:0]              lookup_addr,
    output logic                     mem_req_valid,
    output mem_cmd_t                 mem_req_cmd,
    output logic [31:0]              mem_req_addr,
    input  logic                     mem_credit,
    input  logic                     mem_resp_valid
);

    localparam int CREDIT_W = $clog2(`DC_MEM_CREDITS + 1);

    ctrl_state_t         state;
    ctrl_state_t         state_nxt;
    logic [31:0]         addr_q;
    logic                write_q;
    logic [CREDIT_W-1:0] credits;
    logic                ready_q;
    logic                accept;
    logic                have_credit;

    assign accept      = req_valid && ready_q;
    assign have_credit = (credits != '0);
    assign req_ready   = ready_q;
    assign lookup_addr = addr_q;
    assign resp_valid  = (state == ST_RESPOND);
    assign word_we     = (state == ST_RESPOND) && write_q;
    assign line_we     = (state == ST_REFILL_WAIT) && mem_resp_valid;

    always_comb begin
        state_nxt     = state;
        mem_req_valid = 1'b0;
        mem_req_cmd   = MEM_READ;
        mem_req_addr  = {addr_q[31:4], 4'b0000}; // Refill line address
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_nxt = ST_RESPOND;
                end else if (line_dirty) begin
                    state_nxt = ST_WRITEBACK;
                end else begin
                    state_nxt = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                mem_req_cmd  = MEM_WRITE;
                mem_req_addr = {line_tag, addr_q[4], 4'b0000}; // Victim line
                if (have_credit) begin
                    mem_req_valid = 1'b1;
                    state_nxt     = ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                if (have_credit) begin
                    mem_req_valid = 1'b1;
                    state_nxt     = ST_REFILL_WAIT;
                end
            end
            ST_REFILL_WAIT: begin
                if (mem_resp_valid) begin
                    state_nxt = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            ready_q <= 1'b0;
            credits <= CREDIT_W'(`DC_MEM_CREDITS);
        end else begin
            state   <= state_nxt;
            ready_q <= (state_nxt == ST_IDLE);
            if (mem_credit && !mem_req_valid) begin
                credits <= credits + 1'b1;
            end else if (!mem_credit && mem_req_valid) begin
                credits <= credits - 1'b1;
            end
        end
    end

    // Request held until respond
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
        end
    end

endmodule

// ==== rtl/dcache_align.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_align import dcache_pkg::*; (
    input  access_size_t              size,
    input  logic [1:0]                offset_byte,
    input  logic [`DC_DATA_WIDTH-1:0] old_word,
    input  logic [`DC_DATA_WIDTH-1:0] store_data,
    output logic [`DC_DATA_WIDTH-1:0] load_data,
    output logic [`DC_DATA_WIDTH-1:0] merged_word
);

    logic [`DC_DATA_WIDTH-1:0]   shifted_old;
    logic [`DC_DATA_WIDTH-1:0]   shifted_store;
    logic [`DC_DATA_WIDTH/8-1:0] lane_en;

    assign shifted_old   = old_word >> {offset_byte, 3'b000};
    assign shifted_store = store_data << {offset_byte, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                load_data = {{(`DC_DATA_WIDTH-8){1'b0}}, shifted_old[7:0]};
                lane_en   = 4'b0001 << offset_byte;
            end
            SIZE_HALF: begin
                load_data = {{(`DC_DATA_WIDTH-16){1'b0}}, shifted_old[15:0]};
                lane_en   = 4'b0011 << offset_byte;
            end
            SIZE_WORD: begin
                load_data = old_word;
                lane_en   = 4'b1111;
            end
            default: begin
                load_data = '0; // Unsupported size
                lane_en   = 4'b0000;
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < `DC_DATA_WIDTH/8; b++) begin
            merged_word[b*8 +: 8] = lane_en[b] ? shifted_store[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

endmodule

// ==== rtl/dcache_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_store (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         index,
    input  logic [`DC_TAG_WIDTH-1:0]                     tag,
    input  logic [1:0]                                   offset,
    input  logic                                         word_we,
    input  logic [`DC_DATA_WIDTH-1:0]                    word_wdata,
    input  logic                                         line_we,
    input  logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] line_wdata,
    output logic                                         hit,
    output logic                                         line_dirty,
    output logic [`DC_TAG_WIDTH-1:0]                     line_tag,
    output logic [`DC_WORDS_PER_LINE*`DC_DATA_WIDTH-1:0] line_rdata,
    output logic [`DC_DATA_WIDTH-1:0]                    word_rdata
);

    logic [`DC_DATA_WIDTH-1:0] data_arr [`DC_NUM_LINES][`DC_WORDS_PER_LINE];
    logic [`DC_TAG_WIDTH-1:0]  tag_arr  [`DC_NUM_LINES];
    logic [`DC_NUM_LINES-1:0]  valid;
    logic [`DC_NUM_LINES-1:0]  dirty;

    assign hit        = valid[index] && (tag_arr[index] == tag);
    assign line_dirty = valid[index] && dirty[index];
    assign line_tag   = tag_arr[index];
    assign word_rdata = data_arr[index][offset];

    // Word 0 sits in the low bits of the line
    always_comb begin
        for (int i = 0; i < `DC_WORDS_PER_LINE; i++) begin
            line_rdata[i*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] = data_arr[index][i];
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_arr[index] <= tag;
            for (int i = 0; i < `DC_WORDS_PER_LINE; i++) begin
                data_arr[index][i] <= line_wdata[i*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];
            end
        end
        if (word_we) begin
            data_arr[index][offset] <= word_wdata; // Overrides refill word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (line_we) begin
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0; // Fresh line from memory
            end
            if (word_we) begin
                dirty[index] <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // Encoded like funct3
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } access_size_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_LOOKUP      = 3'd1,
        ST_WRITEBACK   = 3'd2,
        ST_REFILL_REQ  = 3'd3,
        ST_REFILL_WAIT = 3'd4,
        ST_RESPOND     = 3'd5
    } ctrl_state_t;

endpackage

// ==== rtl/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Cache geometry
`define DC_DATA_WIDTH     32
`define DC_WORDS_PER_LINE 4
`define DC_NUM_LINES      2
`define DC_TAG_WIDTH      27

// Credits granted by memory after reset
`define DC_MEM_CREDITS    2

`endif
